// File: hdl/pulse_pkg.sv
package pulse_pkg;

    // ------------------------------
    // field widths
    // ------------------------------
    localparam int SAMPLE_W   = 12;  // adc sample
    localparam int WIDTH_W    = 11;  // pulse width, clock cycles
    localparam int NUM_W      = 11;  // pulse count
    localparam int GAP_W      = 16;  // gap, microseconds
    localparam int CAP_W      = 10;  // capture length / sample index
    localparam int DROP_W     = 8;   // saturating drop counter
    localparam int REG_ADDR_W = 3;
    localparam int REG_DATA_W = 16;

    localparam int CYCLES_PER_US = 125;  // clk_125m ticks per us
    localparam int FIFO_DEPTH    = 8;    // both fifos

    // ------------------------------
    // register map
    // ------------------------------
    localparam logic [REG_ADDR_W-1:0] REG_PULSE_WIDTH = 3'd0;
    localparam logic [REG_ADDR_W-1:0] REG_PULSE_NUM   = 3'd1;
    localparam logic [REG_ADDR_W-1:0] REG_GAP_US      = 3'd2;
    localparam logic [REG_ADDR_W-1:0] REG_CAPTURE_LEN = 3'd3;
    localparam logic [REG_ADDR_W-1:0] REG_CONTROL     = 3'd4;  // bit 0 = start
    localparam logic [REG_ADDR_W-1:0] REG_STATUS      = 3'd5;  // ro: busy, drops

    typedef struct packed {
        logic                  wr;    // 1 = write, 0 = read
        logic [REG_ADDR_W-1:0] addr;
        logic [REG_DATA_W-1:0] data;
    } cfg_req_t;

    typedef struct packed {
        logic [WIDTH_W-1:0] width;
        logic [NUM_W-1:0]   num;
        logic [GAP_W-1:0]   gap_us;
    } pulse_cfg_t;

    typedef struct packed {
        logic [CAP_W-1:0]    idx;    // position in window
        logic [SAMPLE_W-1:0] value;
    } cap_sample_t;

    typedef struct packed {
        logic [REG_DATA_W-1:0] data;
    } rd_rsp_t;

endpackage

// File: hdl/stream_fifo.sv
`timescale 1ns/100ps

module stream_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4
) (
    input  logic     i_clk_125m,
    input  logic     i_reset,
    // write side
    input  payload_t i_data,
    input  logic     i_valid,
    output logic     o_ready,
    // read side
    output payload_t o_data,
    output logic     o_valid,
    input  logic     i_ready
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t           mem [DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;    // occupancy
    logic               push;
    logic               pop;

    assign o_ready = (count != CNT_W'(DEPTH));  // back-pressure when full
    assign o_valid = (count != '0);
    assign o_data  = mem[rd_ptr];               // head of queue
    assign push    = i_valid && o_ready;
    assign pop     = o_valid && i_ready;

    always_ff @(posedge i_clk_125m) begin
        if (push) begin
            mem[wr_ptr] <= i_data;
        end
    end

    always_ff @(posedge i_clk_125m) begin
        if (i_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);  // wrap
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
            end
            case ({push, pop})
                2'b10:   count <= count + CNT_W'(1);
                2'b01:   count <= count - CNT_W'(1);
                default: count <= count;  // both or neither
            endcase
        end
    end

endmodule

// File: hdl/pulse_regs.sv
`timescale 1ns/100ps

module pulse_regs (
    input  logic                         i_clk_125m,
    input  logic                         i_reset,
    input  pulse_pkg::cfg_req_t          i_cfg_req,
    input  logic                         i_cfg_valid,
    output logic                         o_cfg_ready,
    output pulse_pkg::pulse_cfg_t        o_pulse_cfg,
    output logic [pulse_pkg::CAP_W-1:0]  o_capture_len,
    output logic                         o_start,
    input  logic                         i_busy,
    input  logic [pulse_pkg::DROP_W-1:0] i_drop_count,
    output pulse_pkg::rd_rsp_t           o_rsp,
    output logic                         o_rsp_valid,
    input  logic                         i_rsp_ready
);
    import pulse_pkg::*;

    pulse_cfg_t       cfg_q;       // width / num / gap
    logic [CAP_W-1:0] cap_len_q;
    logic             start_q;
    logic             fifo_ready;  // room for one more response
    logic             wr_acc;
    logic             rd_acc;
    rd_rsp_t          rd_rsp;

    // stall only a read that would overflow the response queue
    assign o_cfg_ready = !(i_cfg_valid && !i_cfg_req.wr && !fifo_ready);
    assign wr_acc      = i_cfg_valid && i_cfg_req.wr;
    assign rd_acc      = i_cfg_valid && !i_cfg_req.wr && fifo_ready;

    assign o_pulse_cfg   = cfg_q;
    assign o_capture_len = cap_len_q;
    assign o_start       = start_q;

    // ------------------------------
    // read mux
    // ------------------------------
    always_comb begin
        case (i_cfg_req.addr)
            REG_PULSE_WIDTH: rd_rsp.data = REG_DATA_W'(cfg_q.width);
            REG_PULSE_NUM:   rd_rsp.data = REG_DATA_W'(cfg_q.num);
            REG_GAP_US:      rd_rsp.data = cfg_q.gap_us;
            REG_CAPTURE_LEN: rd_rsp.data = REG_DATA_W'(cap_len_q);
            REG_STATUS:      rd_rsp.data = {i_drop_count, {(REG_DATA_W-DROP_W-1){1'b0}}, i_busy};
            default:         rd_rsp.data = '0;  // control reads back zero
        endcase
    end

    // ------------------------------
    // write decode
    // ------------------------------
    always_ff @(posedge i_clk_125m) begin
        if (i_reset) begin
            cfg_q     <= '0;
            cap_len_q <= '0;
            start_q   <= 1'b0;
        end else begin
            // one-cycle strobe, dropped while a run is in flight
            start_q <= wr_acc && (i_cfg_req.addr == REG_CONTROL) && i_cfg_req.data[0] && !i_busy;
            if (wr_acc) begin
                case (i_cfg_req.addr)
                    REG_PULSE_WIDTH: cfg_q.width  <= i_cfg_req.data[WIDTH_W-1:0];
                    REG_PULSE_NUM:   cfg_q.num    <= i_cfg_req.data[NUM_W-1:0];
                    REG_GAP_US:      cfg_q.gap_us <= i_cfg_req.data[GAP_W-1:0];
                    REG_CAPTURE_LEN: cap_len_q    <= i_cfg_req.data[CAP_W-1:0];
                    default:         ;  // control/status hold nothing
                endcase
            end
        end
    end

    stream_fifo #(
        .payload_t (rd_rsp_t),
        .DEPTH     (FIFO_DEPTH)
    ) rsp_fifo_i (
        .i_clk_125m (i_clk_125m),
        .i_reset    (i_reset),
        .i_data     (rd_rsp),
        .i_valid    (rd_acc),      // lands on the acceptance edge
        .o_ready    (fifo_ready),
        .o_data     (o_rsp),
        .o_valid    (o_rsp_valid),
        .i_ready    (i_rsp_ready)
    );

endmodule

// File: hdl/pulse_gen.sv
`timescale 1ns/100ps

module pulse_gen (
    input  logic                  i_clk_125m,
    input  logic                  i_reset,
    input  logic                  i_start,
    input  pulse_pkg::pulse_cfg_t i_pulse_cfg,
    output logic                  o_pulse,
    output logic                  o_trig,
    output logic                  o_busy
);
    import pulse_pkg::*;

    localparam int PRESC_W = $clog2(CYCLES_PER_US);

    typedef enum logic [1:0] {
        S_IDLE,
        S_HIGH,
        S_GAP
    } state_t;

    state_t             state;
    pulse_cfg_t         cfg_q;      // settings frozen at start
    logic [WIDTH_W-1:0] cyc_cnt;    // 1-based cycle within pulse
    logic [PRESC_W-1:0] presc;      // cycles within current us
    logic [GAP_W-1:0]   us_cnt;     // elapsed us of gap
    logic [NUM_W-1:0]   pulse_cnt;  // pulses completed
    logic               high_done;
    logic               last_pulse;
    logic               us_tick;

    assign high_done  = (cyc_cnt >= cfg_q.width);  // width 0 behaves as 1
    assign last_pulse = (pulse_cnt == cfg_q.num - NUM_W'(1));
    assign us_tick    = (presc == PRESC_W'(CYCLES_PER_US - 1));

    assign o_pulse = (state == S_HIGH);
    assign o_trig  = (state == S_HIGH) && (pulse_cnt == '0) && (cyc_cnt == WIDTH_W'(1));
    assign o_busy  = i_start || (state != S_IDLE);  // covers the strobe cycle too

    // ------------------------------
    // sequencer
    // ------------------------------
    always_ff @(posedge i_clk_125m) begin
        if (i_reset) begin
            state     <= S_IDLE;
            cfg_q     <= '0;
            cyc_cnt   <= '0;
            presc     <= '0;
            us_cnt    <= '0;
            pulse_cnt <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (i_start) begin
                        cfg_q     <= i_pulse_cfg;
                        cyc_cnt   <= WIDTH_W'(1);
                        pulse_cnt <= '0;
                        if (i_pulse_cfg.num != '0) begin  // zero count ends here
                            state <= S_HIGH;
                        end
                    end
                end
                S_HIGH: begin
                    if (high_done) begin
                        pulse_cnt <= pulse_cnt + NUM_W'(1);
                        cyc_cnt   <= WIDTH_W'(1);
                        presc     <= '0;
                        us_cnt    <= '0;
                        if (last_pulse) begin
                            state <= S_IDLE;  // no trailing gap
                        end else if (cfg_q.gap_us != '0) begin
                            state <= S_GAP;
                        end
                    end else begin
                        cyc_cnt <= cyc_cnt + WIDTH_W'(1);
                    end
                end
                S_GAP: begin
                    if (us_tick) begin
                        presc  <= '0;
                        us_cnt <= us_cnt + GAP_W'(1);
                        if (us_cnt == cfg_q.gap_us - GAP_W'(1)) begin
                            state <= S_HIGH;  // next pulse
                        end
                    end else begin
                        presc <= presc + PRESC_W'(1);
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

// File: hdl/adc_capture.sv
`timescale 1ns/100ps

module adc_capture (
    input  logic                           i_clk_125m,
    input  logic                           i_reset,
    input  logic                           i_start,        // clears drop count
    input  logic                           i_trig,         // opens window
    input  logic [pulse_pkg::CAP_W-1:0]    i_capture_len,
    input  logic [pulse_pkg::SAMPLE_W-1:0] i_adc_sample,
    input  logic                           i_adc_valid,
    output pulse_pkg::cap_sample_t         o_sample,
    output logic                           o_sample_valid,
    input  logic                           i_sample_ready,
    output logic [pulse_pkg::DROP_W-1:0]   o_drop_count,
    output logic                           o_busy
);
    import pulse_pkg::*;

    logic              open_q;    // window active
    logic [CAP_W-1:0]  len_q;     // window length, frozen at trigger
    logic [CAP_W-1:0]  idx;       // next sample index
    logic [DROP_W-1:0] drop_cnt;
    logic              take;
    logic              drop;

    assign take = open_q && i_adc_valid;
    assign drop = take && !i_sample_ready;  // fifo full, sample lost

    // no stall path, sample is offered in the cycle it arrives
    assign o_sample_valid = take;
    assign o_sample       = '{idx: idx, value: i_adc_sample};
    assign o_drop_count   = drop_cnt;
    assign o_busy         = open_q;

    // ------------------------------
    // window and index
    // ------------------------------
    always_ff @(posedge i_clk_125m) begin
        if (i_reset) begin
            open_q <= 1'b0;
            len_q  <= '0;
            idx    <= '0;
        end else if (i_trig) begin
            open_q <= (i_capture_len != '0);  // zero length, nothing taken
            len_q  <= i_capture_len;
            idx    <= '0;
        end else if (take) begin
            idx <= idx + CAP_W'(1);  // consumed even if dropped
            if (idx == len_q - CAP_W'(1)) begin
                open_q <= 1'b0;      // last sample of window
            end
        end
    end

    // ------------------------------
    // drop counter, saturating
    // ------------------------------
    always_ff @(posedge i_clk_125m) begin
        if (i_reset || i_start) begin
            drop_cnt <= '0;
        end else if (drop && (drop_cnt != '1)) begin
            drop_cnt <= drop_cnt + DROP_W'(1);
        end
    end

endmodule

// File: hdl/pulse_capture_top.sv
`timescale 1ns/100ps

module pulse_capture_top (
    input  logic                           i_clk_125m,
    input  logic                           i_reset,
    // config requests
    input  pulse_pkg::cfg_req_t            i_cfg_req,
    input  logic                           i_cfg_valid,
    output logic                           o_cfg_ready,
    // adc
    input  logic [pulse_pkg::SAMPLE_W-1:0] i_adc_sample,
    input  logic                           i_adc_valid,
    // sample stream
    output pulse_pkg::cap_sample_t         o_cap_sample,
    output logic                           o_cap_valid,
    input  logic                           i_cap_ready,
    // read response stream
    output pulse_pkg::rd_rsp_t             o_rsp,
    output logic                           o_rsp_valid,
    input  logic                           i_rsp_ready,
    // pulse outputs
    output logic                           o_pulse,
    output logic                           o_trig
);
    import pulse_pkg::*;

    pulse_cfg_t        pulse_cfg;
    logic [CAP_W-1:0]  capture_len;
    logic              start;
    logic              gen_busy;
    logic              cap_busy;
    logic [DROP_W-1:0] drop_count;
    cap_sample_t       cap_rec;        // tagged sample into fifo
    logic              cap_rec_valid;
    logic              cap_rec_ready;

    // ------------------------------
    // control
    // ------------------------------
    pulse_regs regs_i (
        .i_clk_125m    (i_clk_125m),
        .i_reset       (i_reset),
        .i_cfg_req     (i_cfg_req),
        .i_cfg_valid   (i_cfg_valid),
        .o_cfg_ready   (o_cfg_ready),
        .o_pulse_cfg   (pulse_cfg),
        .o_capture_len (capture_len),
        .o_start       (start),
        .i_busy        (gen_busy || cap_busy),  // pulses or open window
        .i_drop_count  (drop_count),
        .o_rsp         (o_rsp),
        .o_rsp_valid   (o_rsp_valid),
        .i_rsp_ready   (i_rsp_ready)
    );

    pulse_gen gen_i (
        .i_clk_125m  (i_clk_125m),
        .i_reset     (i_reset),
        .i_start     (start),
        .i_pulse_cfg (pulse_cfg),
        .o_pulse     (o_pulse),
        .o_trig      (o_trig),
        .o_busy      (gen_busy)
    );

    // ------------------------------
    // capture path
    // ------------------------------
    adc_capture cap_i (
        .i_clk_125m     (i_clk_125m),
        .i_reset        (i_reset),
        .i_start        (start),
        .i_trig         (o_trig),
        .i_capture_len  (capture_len),
        .i_adc_sample   (i_adc_sample),
        .i_adc_valid    (i_adc_valid),
        .o_sample       (cap_rec),
        .o_sample_valid (cap_rec_valid),
        .i_sample_ready (cap_rec_ready),
        .o_drop_count   (drop_count),
        .o_busy         (cap_busy)
    );

    stream_fifo #(
        .payload_t (cap_sample_t),
        .DEPTH     (FIFO_DEPTH)
    ) cap_fifo_i (
        .i_clk_125m (i_clk_125m),
        .i_reset    (i_reset),
        .i_data     (cap_rec),
        .i_valid    (cap_rec_valid),
        .o_ready    (cap_rec_ready),
        .o_data     (o_cap_sample),
        .o_valid    (o_cap_valid),
        .i_ready    (i_cap_ready)
    );

endmodule

// File: dv/tb_clk_gen.sv
`timescale 1ns/100ps

module tb_clk_gen (
    output logic o_clk,
    output logic o_reset
);

    initial begin
        o_clk = 1'b0;
        forever #5 o_clk = ~o_clk;  // 10 ns period
    end

    initial begin
        o_reset = 1'b1;
        repeat (3) @(posedge o_clk);  // three reset cycles
        @(negedge o_clk);
        o_reset = 1'b0;
    end

endmodule

// File: dv/pulse_capture_chk.sv
`timescale 1ns/100ps

module pulse_capture_chk (
    input logic                   i_clk_125m,
    input logic                   i_reset,
    input pulse_pkg::cap_sample_t o_cap_sample,
    input logic                   o_cap_valid,
    input logic                   i_cap_ready,
    input pulse_pkg::rd_rsp_t     o_rsp,
    input logic                   o_rsp_valid,
    input logic                   i_rsp_ready,
    input logic                   o_pulse,
    input logic                   o_trig
);

    int fail_cnt = 0;  // assertion failures so far

    // ------------------------------
    // output stream handshakes
    // ------------------------------
    a_cap_hold: assert property (@(posedge i_clk_125m) disable iff (i_reset)
        o_cap_valid && !i_cap_ready |=> o_cap_valid && $stable(o_cap_sample))
        else begin
            fail_cnt = fail_cnt + 1;
            $error("sample stream dropped valid or changed payload while stalled");
        end

    a_rsp_hold: assert property (@(posedge i_clk_125m) disable iff (i_reset)
        o_rsp_valid && !i_rsp_ready |=> o_rsp_valid && $stable(o_rsp))
        else begin
            fail_cnt = fail_cnt + 1;
            $error("response stream dropped valid or changed payload while stalled");
        end

    // ------------------------------
    // trigger shape
    // ------------------------------
    a_trig_one: assert property (@(posedge i_clk_125m) disable iff (i_reset)
        o_trig |=> !o_trig)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("trigger longer than one cycle");
        end

    a_trig_rise: assert property (@(posedge i_clk_125m) disable iff (i_reset)
        o_trig |-> o_pulse && !$past(o_pulse))
        else begin
            fail_cnt = fail_cnt + 1;
            $error("trigger not on a rising pulse edge");
        end

endmodule

bind pulse_capture_top pulse_capture_chk chk_i (.*);

// File: dv/pulse_capture_tb.sv
`timescale 1ns/100ps

module pulse_capture_tb;
    import pulse_pkg::*;

    logic                clk;
    logic                rst;
    cfg_req_t            cfg_req;
    logic                cfg_valid;
    logic                cfg_ready;
    logic [SAMPLE_W-1:0] adc_sample;
    logic                adc_valid;
    cap_sample_t         cap_sample;
    logic                cap_valid;
    logic                cap_ready;
    rd_rsp_t             rsp;
    logic                rsp_valid;
    logic                rsp_ready;
    logic                pulse;
    logic                trig;

    int                  cyc;          // posedge number
    logic                prev_pulse;
    logic                armed;        // trigger seen, recording adc
    int                  rise_q[$];
    int                  fall_q[$];
    int                  trig_q[$];
    int                  acc_q[$];     // accepted start writes
    logic [SAMPLE_W-1:0] adc_hist[$];  // valid samples after trigger
    cap_sample_t         cap_got[$];
    rd_rsp_t             rsp_got[$];
    int                  errs;
    int                  checks;
    int                  errs_at_start;

    tb_clk_gen clk_gen_i (.o_clk(clk), .o_reset(rst));

    pulse_capture_top dut_i (
        .i_clk_125m (clk),       .i_reset     (rst),
        .i_cfg_req  (cfg_req),   .i_cfg_valid (cfg_valid),  .o_cfg_ready (cfg_ready),
        .i_adc_sample (adc_sample), .i_adc_valid (adc_valid),
        .o_cap_sample (cap_sample), .o_cap_valid (cap_valid), .i_cap_ready (cap_ready),
        .o_rsp      (rsp),       .o_rsp_valid (rsp_valid),  .i_rsp_ready (rsp_ready),
        .o_pulse    (pulse),     .o_trig      (trig)
    );

    // ------------------------------
    // reference model
    // ------------------------------
    function automatic int rise_offset(int w, int g, int k);
        return 2 + k * (w + g * CYCLES_PER_US);  // from start acceptance edge
    endfunction

    function automatic int train_cycles(int w, int n, int g);
        return n * (w + g * CYCLES_PER_US) + 4;
    endfunction

    function automatic cap_sample_t exp_record(int i);
        cap_sample_t r;
        r.idx   = CAP_W'(i);
        r.value = adc_hist[i];  // i-th valid sample after trigger
        return r;
    endfunction

    function automatic int exp_drops(int len, int room);
        int d;
        d = (len > room) ? len - room : 0;
        return (d > 255) ? 255 : d;  // saturating
    endfunction

    function automatic rd_rsp_t exp_status(logic busy, int drops);
        rd_rsp_t r;
        r.data = {drops[7:0], 7'b0, busy};
        return r;
    endfunction

    // ------------------------------
    // compare tasks
    // ------------------------------
    task automatic check_sample(cap_sample_t got, cap_sample_t exp, string what);
        checks++;
        if (got !== exp) begin
            errs++;
            $display("Error [%0t] %s: got idx %0d val %h, exp idx %0d val %h",
                     $time, what, got.idx, got.value, exp.idx, exp.value);
        end
    endtask

    task automatic check_rsp(rd_rsp_t got, rd_rsp_t exp, string what);
        checks++;
        if (got !== exp) begin
            errs++;
            $display("Error [%0t] %s: got %h, exp %h", $time, what, got.data, exp.data);
        end
    endtask

    task automatic check_cycle(int got, int exp, string what);
        checks++;
        if (got != exp) begin
            errs++;
            $display("Error [%0t] %s: got %0d, exp %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(logic got, logic exp, string what);
        checks++;
        if (got !== exp) begin
            errs++;
            $display("Error [%0t] %s: got %b, exp %b", $time, what, got, exp);
        end
    endtask

    // ------------------------------
    // monitor, sampled at posedge
    // ------------------------------
    always @(posedge clk) begin
        cyc = cyc + 1;
        if (rst) begin
            prev_pulse = 1'b0;
            armed      = 1'b0;
        end else begin
            if (cfg_valid && cfg_ready && cfg_req.wr && cfg_req.addr == REG_CONTROL &&
                cfg_req.data[0]) acc_q.push_back(cyc);
            if (pulse && !prev_pulse) rise_q.push_back(cyc);
            if (!pulse && prev_pulse) fall_q.push_back(cyc);
            if (trig) trig_q.push_back(cyc);
            if (armed && adc_valid) adc_hist.push_back(adc_sample);
            if (trig) begin
                adc_hist.delete();  // window restarts
                armed = 1'b1;
            end
            if (cap_valid && cap_ready) cap_got.push_back(cap_sample);
            if (rsp_valid && rsp_ready) rsp_got.push_back(rsp);
            prev_pulse = pulse;
        end
    end

    always @(negedge clk) begin
        adc_valid  = 1'($urandom_range(0, 1));  // random adc strobe
        adc_sample = SAMPLE_W'($urandom);
    end

    // ------------------------------
    // bus tasks
    // ------------------------------
    task automatic cfg_xfer(logic wr, logic [REG_ADDR_W-1:0] addr, logic [REG_DATA_W-1:0] data);
        @(negedge clk);
        cfg_req   = '{wr: wr, addr: addr, data: data};
        cfg_valid = 1'b1;
        #1;
        while (!cfg_ready) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);  // accepted on the posedge between
        cfg_valid = 1'b0;
    endtask

    task automatic wait_rsp(output rd_rsp_t r);
        int n;
        n = 0;
        while (rsp_got.size() == 0 && n < 200) begin
            @(negedge clk);
            n++;
        end
        if (rsp_got.size() == 0) begin
            errs++;
            $display("No read response arrived within 200 cycles at %0t", $time);
            r = '0;
        end else begin
            r = rsp_got.pop_front();
        end
    endtask

    task automatic wait_idle();
        rd_rsp_t r;
        int      n;
        n = 0;
        r.data = 16'h1;
        while (r.data[0] && n < 1000) begin
            cfg_xfer(1'b0, REG_STATUS, '0);
            wait_rsp(r);
            n++;
        end
        if (r.data[0]) begin
            errs++;
            $display("Busy flag never cleared at %0t", $time);
        end
    endtask

    task automatic wait_records(int n);
        int k;
        k = 0;
        while (cap_got.size() < n && k < 500) begin
            @(negedge clk);
            k++;
        end
    endtask

    task automatic clear_queues();
        rise_q.delete();
        fall_q.delete();
        trig_q.delete();
        acc_q.delete();
        cap_got.delete();
        rsp_got.delete();
    endtask

    task automatic check_train(int w, int n, int g);
        check_cycle(rise_q.size(), n, "pulse count");
        check_cycle(trig_q.size(), (n > 0) ? 1 : 0, "trigger count");
        if (rise_q.size() == n && fall_q.size() == n && n > 0) begin
            for (int k = 0; k < n; k++) begin
                check_cycle(rise_q[k] - acc_q[0], rise_offset(w, g, k), "pulse rise");
                check_cycle(fall_q[k] - rise_q[k], w, "pulse width");
            end
            if (trig_q.size() == 1) check_cycle(trig_q[0], rise_q[0], "trigger position");
        end
    endtask

    task automatic start_test();
        errs_at_start = errs;
        clear_queues();
    endtask

    task automatic end_test(string name);
        $display("test %-24s %s", name, (errs == errs_at_start) ? "ok" : "FAILED");
    endtask

    // ------------------------------
    // watchdog
    // ------------------------------
    initial begin
        int limit;
        limit = train_cycles(3, 4, 1) + 2 * train_cycles(2, 1, 0) + 2 * train_cycles(2, 2, 1)
              + 4 * (20 + 40 + 150) + 4000;  // polling and fifo drain overhead
        repeat (limit) @(posedge clk);
        $display("Watchdog expired after %0d cycles, run did not complete", limit);
        $display("Simulation finished: FAIL");
        $finish;
    end

    // ------------------------------
    // tests
    // ------------------------------
    initial begin
        rd_rsp_t     r;
        rd_rsp_t     exp_r;
        logic [15:0] vals [4];
        int          n;
        void'($urandom(32'hc5d9_cd96));
        cfg_req = '0;
        cfg_valid = 1'b0;
        adc_sample = '0;
        adc_valid = 1'b0;
        cap_ready = 1'b1;
        rsp_ready = 1'b1;
        cyc = 0;
        errs = 0;
        checks = 0;
        @(negedge rst);

        start_test();  // 1: register read-back
        cfg_xfer(1'b0, REG_STATUS, '0);
        wait_rsp(r);
        check_rsp(r, exp_status(1'b0, 0), "status after reset");
        vals = '{16'd5, 16'd7, 16'd300, 16'd17};
        for (int a = 0; a < 4; a++) cfg_xfer(1'b1, REG_ADDR_W'(a), vals[a]);
        for (int a = 0; a < 4; a++) cfg_xfer(1'b0, REG_ADDR_W'(a), '0);
        for (int a = 0; a < 4; a++) begin
            wait_rsp(r);
            exp_r.data = vals[a];
            check_rsp(r, exp_r, "read-back");
        end
        end_test("register read-back");

        start_test();  // 2: pulse train timing
        cfg_xfer(1'b1, REG_PULSE_WIDTH, 16'd3);
        cfg_xfer(1'b1, REG_PULSE_NUM, 16'd4);
        cfg_xfer(1'b1, REG_GAP_US, 16'd1);
        cfg_xfer(1'b1, REG_CAPTURE_LEN, 16'd0);
        cfg_xfer(1'b1, REG_CONTROL, 16'd1);
        wait_idle();
        check_train(3, 4, 1);
        end_test("pulse train");

        start_test();  // 3: capture with ready high
        cfg_xfer(1'b1, REG_PULSE_WIDTH, 16'd2);
        cfg_xfer(1'b1, REG_PULSE_NUM, 16'd1);
        cfg_xfer(1'b1, REG_GAP_US, 16'd0);
        cfg_xfer(1'b1, REG_CAPTURE_LEN, 16'd20);
        cfg_xfer(1'b1, REG_CONTROL, 16'd1);
        wait_idle();
        wait_records(20);
        check_cycle(cap_got.size(), 20, "record count");
        for (int i = 0; i < cap_got.size() && i < 20; i++) begin
            check_sample(cap_got[i], exp_record(i), "capture record");
        end
        cfg_xfer(1'b0, REG_STATUS, '0);
        wait_rsp(r);
        check_rsp(r, exp_status(1'b0, exp_drops(20, 20)), "status no drops");
        end_test("capture");

        start_test();  // 4: capture under back-pressure
        @(negedge clk);
        cap_ready = 1'b0;
        cfg_xfer(1'b1, REG_CAPTURE_LEN, 16'd40);
        cfg_xfer(1'b1, REG_CONTROL, 16'd1);
        wait_idle();
        cfg_xfer(1'b0, REG_STATUS, '0);
        wait_rsp(r);
        check_rsp(r, exp_status(1'b0, exp_drops(40, FIFO_DEPTH)), "status drops");
        @(negedge clk);
        cap_ready = 1'b1;
        wait_records(FIFO_DEPTH);
        repeat (4) @(negedge clk);
        check_cycle(cap_got.size(), FIFO_DEPTH, "kept record count");
        for (int i = 0; i < cap_got.size() && i < FIFO_DEPTH; i++) begin
            check_sample(cap_got[i], exp_record(i), "kept record");
        end
        end_test("capture back-pressure");

        start_test();  // 5: start while busy, zero count
        cfg_xfer(1'b1, REG_CAPTURE_LEN, 16'd150);  // window outlasts the train
        cfg_xfer(1'b1, REG_PULSE_NUM, 16'd2);
        cfg_xfer(1'b1, REG_GAP_US, 16'd1);
        cfg_xfer(1'b1, REG_CONTROL, 16'd1);
        n = 0;
        while (fall_q.size() < 2 && n < 500) begin
            @(negedge clk);
            n++;
        end
        cfg_xfer(1'b1, REG_CONTROL, 16'd1);  // generator idle, window still open
        wait_idle();
        check_train(2, 2, 1);
        clear_queues();
        cfg_xfer(1'b1, REG_PULSE_NUM, 16'd0);
        cfg_xfer(1'b1, REG_CONTROL, 16'd1);
        wait_idle();
        repeat (4) @(negedge clk);
        check_train(2, 0, 1);
        end_test("busy start, zero count");

        start_test();  // 6: response fifo stall
        vals = '{16'd9, 16'd0, 16'd1, 16'd33};
        cfg_xfer(1'b1, REG_PULSE_WIDTH, vals[0]);
        cfg_xfer(1'b1, REG_CAPTURE_LEN, vals[3]);
        @(negedge clk);
        rsp_ready = 1'b0;
        for (int i = 0; i < FIFO_DEPTH; i++) cfg_xfer(1'b0, REG_ADDR_W'(i % 4), '0);
        @(negedge clk);
        cfg_req   = '{wr: 1'b0, addr: REG_ADDR_W'(FIFO_DEPTH % 4), data: '0};
        cfg_valid = 1'b1;
        #1;
        check_flag(cfg_ready, 1'b0, "cfg ready with full response fifo");
        @(negedge clk);
        rsp_ready = 1'b1;
        #1;
        while (!cfg_ready) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        cfg_valid = 1'b0;
        for (int i = 0; i <= FIFO_DEPTH; i++) begin
            wait_rsp(r);
            exp_r.data = vals[i % 4];
            check_rsp(r, exp_r, "stalled read");
        end
        end_test("response stall");

        errs = errs + dut_i.chk_i.fail_cnt;  // bound assertion failures
        $display("checks %0d, errors %0d", checks, errs);
        if (errs == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: all.f
hdl/pulse_pkg.sv
hdl/stream_fifo.sv
hdl/pulse_regs.sv
hdl/pulse_gen.sv
hdl/adc_capture.sv
hdl/pulse_capture_top.sv
dv/tb_clk_gen.sv
dv/pulse_capture_chk.sv
dv/pulse_capture_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= pulse_capture_tb
RTL_TOP   ?= pulse_capture_top
FLIST     ?= all.f
BUILD     ?= obj_dir
VFLAGS    ?= --timing --assert -j 0
PASS_MSG  ?= Simulation finished: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

$(BUILD)/V$(TOP): $(FLIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD)

sim: $(BUILD)/V$(TOP)
	@out="$$(./$(BUILD)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD)
